// File: memPkg.sv
package memPkg;

    // one RAM location
    typedef logic [7:0] byteT;

    // assembled instruction or load/store data
    typedef logic [31:0] wordT;

    // transfer length minus one, 0 is one byte and 3 is four bytes
    typedef logic [1:0] lenT;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } memOpE;

    typedef enum logic {
        PORT_INST = 1'b0,
        PORT_LS   = 1'b1
    } portE;

    typedef enum logic {
        ENG_IDLE = 1'b0,
        ENG_BUSY = 1'b1
    } engStateE;

    // fetch always moves a full word
    localparam lenT INST_LEN = 2'd3;

endpackage

// File: byteRam.sv
`timescale 1ns/100ps

module byteRam import memPkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              wrEn,
    input  byteT              wrData,
    output byteT              rdData
);

    localparam int DEPTH = 2 ** ADDR_W;

    byteT mem [0:DEPTH-1];

    // read data is available in the same cycle as the address
    assign rdData = mem[addr];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

endmodule

// File: memReqSlots.sv
`timescale 1ns/100ps

module memReqSlots import memPkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instEn,
    input  logic [ADDR_W-1:0] instAddr,
    input  logic              dataEn,
    input  memOpE             lsOp,
    input  logic [ADDR_W-1:0] dataAddr,
    input  lenT               lsLen,
    input  wordT              storeData,
    input  logic              instTake,
    input  logic              lsTake,
    output logic              instFree,
    output logic              lsFree,
    output logic              instPend,
    output logic [ADDR_W-1:0] instPendAddr,
    output logic              lsPend,
    output memOpE             lsPendOp,
    output logic [ADDR_W-1:0] lsPendAddr,
    output lenT               lsPendLen,
    output wordT              lsPendData
);

    logic              instFull;
    logic [ADDR_W-1:0] instAddrQ;

    logic              lsFull;
    memOpE             lsOpQ;
    logic [ADDR_W-1:0] lsAddrQ;
    lenT               lsLenQ;
    wordT              lsDataQ;

    assign instFree = !instFull;
    assign lsFree   = !lsFull;

    // an empty slot passes a new request straight through to the engine
    assign instPend     = instFull || instEn;
    assign instPendAddr = instFull ? instAddrQ : instAddr;

    assign lsPend     = lsFull || dataEn;
    assign lsPendOp   = lsFull ? lsOpQ   : lsOp;
    assign lsPendAddr = lsFull ? lsAddrQ : dataAddr;
    assign lsPendLen  = lsFull ? lsLenQ  : lsLen;
    assign lsPendData = lsFull ? lsDataQ : storeData;

    // slot occupancy
    // a take with an empty slot consumed the bypassed request, so nothing is stored
    always_ff @(posedge clk) begin
        if (rst) begin
            instFull <= 1'b0;
            lsFull   <= 1'b0;
        end else begin
            if (instTake) begin
                instFull <= 1'b0;
            end else if (instEn && !instFull) begin
                instFull <= 1'b1;
            end

            if (lsTake) begin
                lsFull <= 1'b0;
            end else if (dataEn && !lsFull) begin
                lsFull <= 1'b1;
            end
        end
    end

    // request payload, only meaningful while the slot is full
    always_ff @(posedge clk) begin
        if (instEn && !instFull) begin
            instAddrQ <= instAddr;
        end
        if (dataEn && !lsFull) begin
            lsOpQ   <= lsOp;
            lsAddrQ <= dataAddr;
            lsLenQ  <= lsLen;
            lsDataQ <= storeData;
        end
    end

endmodule

// File: memSequencer.sv
`timescale 1ns/100ps

module memSequencer import memPkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instPend,
    input  logic [ADDR_W-1:0] instPendAddr,
    input  logic              lsPend,
    input  memOpE             lsPendOp,
    input  logic [ADDR_W-1:0] lsPendAddr,
    input  lenT               lsPendLen,
    input  wordT              lsPendData,
    input  byteT              ramRdData,
    output logic              instTake,
    output logic              lsTake,
    output logic [ADDR_W-1:0] ramAddr,
    output logic              ramWrEn,
    output byteT              ramWrData,
    output logic              instValid,
    output wordT              inst,
    output logic              lsDone,
    output wordT              loadData
);

    engStateE          state;
    portE              port;
    memOpE             op;
    logic [ADDR_W-1:0] addr;
    lenT               len;
    lenT               stage;
    wordT              storeWord;
    wordT              rdWord;

    logic              lastByte;
    logic              canStart;
    logic              startReq;
    wordT              mergedWord;

    portE              nextPort;
    memOpE             nextOp;
    logic [ADDR_W-1:0] nextAddr;
    lenT               nextLen;

    assign lastByte = (state == ENG_BUSY) && (stage == len);

    // the engine can take a request when idle or on its final byte
    assign canStart = (state == ENG_IDLE) || lastByte;

    // load/store has priority over fetch
    assign lsTake   = canStart && lsPend;
    assign instTake = canStart && instPend && !lsPend;
    assign startReq = lsTake || instTake;

    always_comb begin
        if (lsPend) begin
            nextPort = PORT_LS;
            nextOp   = lsPendOp;
            nextAddr = lsPendAddr;
            nextLen  = lsPendLen;
        end else begin
            nextPort = PORT_INST;
            nextOp   = OP_READ;
            nextAddr = instPendAddr;
            nextLen  = INST_LEN;
        end
    end

    // current read byte dropped into its little-endian lane
    always_comb begin
        mergedWord = rdWord;
        mergedWord[{stage, 3'b000} +: 8] = ramRdData;
    end

    assign ramAddr   = addr;
    assign ramWrEn   = (state == ENG_BUSY) && (op == OP_WRITE);
    assign ramWrData = storeWord[{stage, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ENG_IDLE;
            stage     <= '0;
            instValid <= 1'b0;
            lsDone    <= 1'b0;
        end else begin
            instValid <= 1'b0;
            lsDone    <= 1'b0;
            if (lastByte) begin
                instValid <= (port == PORT_INST);
                lsDone    <= (port == PORT_LS);
            end

            if (startReq) begin
                state <= ENG_BUSY;
                stage <= '0;
            end else if (lastByte) begin
                state <= ENG_IDLE;
                stage <= '0;
            end else if (state == ENG_BUSY) begin
                stage <= stage + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // results hold their value until the next completion of that port
        if (lastByte) begin
            if (port == PORT_INST) begin
                inst <= mergedWord;
            end else if (op == OP_READ) begin
                loadData <= mergedWord;
            end
        end

        if (startReq) begin
            port   <= nextPort;
            op     <= nextOp;
            addr   <= nextAddr;
            len    <= nextLen;
            rdWord <= '0;
            if (lsTake) begin
                storeWord <= lsPendData;
            end
        end else if (state == ENG_BUSY) begin
            addr   <= addr + 1'b1;
            rdWord <= mergedWord;
        end
    end

endmodule

// File: memSubsys.sv
`timescale 1ns/100ps

module memSubsys import memPkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instEn,
    input  logic [ADDR_W-1:0] instAddr,
    output logic              instFree,
    output logic              instValid,
    output wordT              inst,
    input  logic              dataEn,
    input  memOpE             lsOp,
    input  logic [ADDR_W-1:0] dataAddr,
    input  lenT               lsLen,
    input  wordT              storeData,
    output logic              lsFree,
    output logic              lsDone,
    output wordT              loadData
);

    logic              instPend;
    logic [ADDR_W-1:0] instPendAddr;
    logic              lsPend;
    memOpE             lsPendOp;
    logic [ADDR_W-1:0] lsPendAddr;
    lenT               lsPendLen;
    wordT              lsPendData;
    logic              instTake;
    logic              lsTake;

    logic [ADDR_W-1:0] ramAddr;
    logic              ramWrEn;
    byteT              ramWrData;
    byteT              ramRdData;

    memReqSlots #(
        .ADDR_W (ADDR_W)
    ) slots (
        .clk          (clk),
        .rst          (rst),
        .instEn       (instEn),
        .instAddr     (instAddr),
        .dataEn       (dataEn),
        .lsOp         (lsOp),
        .dataAddr     (dataAddr),
        .lsLen        (lsLen),
        .storeData    (storeData),
        .instTake     (instTake),
        .lsTake       (lsTake),
        .instFree     (instFree),
        .lsFree       (lsFree),
        .instPend     (instPend),
        .instPendAddr (instPendAddr),
        .lsPend       (lsPend),
        .lsPendOp     (lsPendOp),
        .lsPendAddr   (lsPendAddr),
        .lsPendLen    (lsPendLen),
        .lsPendData   (lsPendData)
    );

    memSequencer #(
        .ADDR_W (ADDR_W)
    ) seq (
        .clk          (clk),
        .rst          (rst),
        .instPend     (instPend),
        .instPendAddr (instPendAddr),
        .lsPend       (lsPend),
        .lsPendOp     (lsPendOp),
        .lsPendAddr   (lsPendAddr),
        .lsPendLen    (lsPendLen),
        .lsPendData   (lsPendData),
        .ramRdData    (ramRdData),
        .instTake     (instTake),
        .lsTake       (lsTake),
        .ramAddr      (ramAddr),
        .ramWrEn      (ramWrEn),
        .ramWrData    (ramWrData),
        .instValid    (instValid),
        .inst         (inst),
        .lsDone       (lsDone),
        .loadData     (loadData)
    );

    byteRam #(
        .ADDR_W (ADDR_W)
    ) ram (
        .clk    (clk),
        .addr   (ramAddr),
        .wrEn   (ramWrEn),
        .wrData (ramWrData),
        .rdData (ramRdData)
    );

endmodule

// File: memSubsys_checker.sv
`timescale 1ns/100ps

module memSubsys_checker import memPkg::*; (
    input logic     clk,
    input logic     rst,
    input engStateE state,
    input logic     instValid,
    input logic     lsDone,
    input logic     ramWrEn,
    input logic     instTake,
    input logic     lsTake,
    input logic     instPend,
    input logic     lsPend
);

    // completions are serial, so only one port can finish per cycle
    oneDone: assert property (@(posedge clk) disable iff (rst) !(instValid && lsDone))
        else $error("instValid and lsDone are high in the same cycle");

    wrWhileBusy: assert property (@(posedge clk) disable iff (rst) ramWrEn |-> state == ENG_BUSY)
        else $error("ramWrEn is high while the engine is idle");

    instTakePend: assert property (@(posedge clk) disable iff (rst) instTake |-> instPend)
        else $error("instTake without a pending fetch");

    lsTakePend: assert property (@(posedge clk) disable iff (rst) lsTake |-> lsPend)
        else $error("lsTake without a pending load/store");

endmodule

bind memSequencer memSubsys_checker protocolChk (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .instValid (instValid),
    .lsDone    (lsDone),
    .ramWrEn   (ramWrEn),
    .instTake  (instTake),
    .lsTake    (lsTake),
    .instPend  (instPend),
    .lsPend    (lsPend)
);

// File: memSubsys_tb.sv
`timescale 1ns/100ps

module memSubsys_tb
    import memPkg::*;
();

    localparam int ADDR_W = 12;
    localparam int MEM_SIZE = 2 ** ADDR_W;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_LS = 400;
    localparam int NUM_INST = 300;
    // two extra requests come from the lone latency tests
    localparam int TIMEOUT_CYCLES = 20 * (NUM_LS + NUM_INST + 2) + RESET_CYCLES;
    // at most a slot and an engine transfer per port remain after the last send
    localparam int DRAIN_CYCLES = 40;
    localparam logic [ADDR_W-1:0] WIN_BASE = 12'h300;

    typedef struct packed {
        memOpE             op;
        logic [ADDR_W-1:0] addr;
        lenT               len;
        wordT              data;
    } lsReqT;

    logic              clk;
    logic              rst;
    logic              instEn;
    logic [ADDR_W-1:0] instAddr;
    logic              instFree;
    logic              instValid;
    wordT              inst;
    logic              dataEn;
    memOpE             lsOp;
    logic [ADDR_W-1:0] dataAddr;
    lenT               lsLen;
    wordT              storeData;
    logic              lsFree;
    logic              lsDone;
    wordT              loadData;

    byteT              modelMem [0:MEM_SIZE-1];
    logic [ADDR_W-1:0] instQ [$];
    lsReqT             lsQ [$];
    logic [31:0]       seed = 32'h0f8c_1904;
    int                valueErrors = 0;
    int                otherErrors = 0;
    int                instSent = 0;
    int                lsSent = 0;
    int                cycleCount = 0;

    memSubsys #(.ADDR_W(ADDR_W)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    // start contents differ per address so stray reads show up
    function automatic byteT fillByte(input int a);
        return byteT'((a * 37) ^ (a >> 5));
    endfunction

    // little-endian, zero-extended above the last byte
    function automatic wordT modelWord(input logic [ADDR_W-1:0] a, input lenT l);
        wordT w;
        w = '0;
        for (int k = 0; k <= int'(l); k++) begin
            w[8*k +: 8] = modelMem[a + ADDR_W'(k)];
        end
        return w;
    endfunction

    function automatic void storeModel(input logic [ADDR_W-1:0] a, input lenT l, input wordT d);
        for (int k = 0; k <= int'(l); k++) begin
            modelMem[a + ADDR_W'(k)] = d[8*k +: 8];
        end
    endfunction

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkLen(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkResults();
        logic [ADDR_W-1:0] a;
        lsReqT             r;
        if (instValid && instQ.size() == 0) begin
            $display("ERROR: instValid pulsed with no outstanding fetch");
            otherErrors++;
        end else if (instValid) begin
            a = instQ.pop_front();
            checkWord($sformatf("fetch at %h", a), modelWord(a, INST_LEN), inst);
        end
        if (lsDone && lsQ.size() == 0) begin
            $display("ERROR: lsDone pulsed with no outstanding load/store");
            otherErrors++;
        end else if (lsDone) begin
            r = lsQ.pop_front();
            if (r.op == OP_WRITE) begin
                storeModel(r.addr, r.len, r.data);
            end else begin
                checkWord($sformatf("load of %0d bytes at %h", int'(r.len) + 1, r.addr),
                          modelWord(r.addr, r.len), loadData);
            end
        end
    endtask

    // one cycle: enables last a single cycle, results are stable at the falling edge
    task automatic tick();
        @(negedge clk);
        instEn = 1'b0;
        dataEn = 1'b0;
        checkResults();
    endtask

    task automatic sendFetch(input logic [ADDR_W-1:0] a);
        instEn = 1'b1;
        instAddr = a;
        instQ.push_back(a);
        instSent++;
    endtask

    task automatic sendLs(input memOpE op, input logic [ADDR_W-1:0] a, input lenT l, input wordT d);
        lsReqT r;
        r.op = op;
        r.addr = a;
        r.len = l;
        r.data = d;
        dataEn = 1'b1;
        lsOp = op;
        dataAddr = a;
        lsLen = l;
        storeData = d;
        lsQ.push_back(r);
        lsSent++;
    endtask

    // lone request on an idle engine, pulse expected L+1 cycles after the accepting edge
    task automatic timeLone(input string name, input portE p, input lenT l,
                            input logic [ADDR_W-1:0] a);
        int n;
        if (p == PORT_INST) begin
            sendFetch(a);
        end else begin
            sendLs(OP_READ, a, l, '0);
        end
        n = 0;
        do begin
            tick();
            n++;
        end while (!(p == PORT_INST ? instValid : lsDone) && n < 40);
        checkLen(name, int'(l) + 1, n - 1);
    endtask

    initial begin
        logic [15:0] r;
        int          drain;
        rst = 1'b1;
        instEn = 1'b0;
        instAddr = '0;
        dataEn = 1'b0;
        lsOp = OP_READ;
        dataAddr = '0;
        lsLen = '0;
        storeData = '0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            modelMem[i] = fillByte(i);
            dut.ram.mem[i] = fillByte(i);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!instFree || !lsFree) begin
            $display("ERROR: a free level is low right after reset");
            otherErrors++;
        end
        // any pulse here has an empty queue and is flagged
        repeat (5) tick();
        timeLone("lone fetch latency", PORT_INST, INST_LEN, WIN_BASE + 12'h010);
        repeat (3) tick();
        timeLone("lone one-byte load latency", PORT_LS, 2'd0, WIN_BASE + 12'h021);
        repeat (3) tick();

        while (instSent < NUM_INST + 1 || lsSent < NUM_LS + 1) begin
            tick();
            r = nextRand();
            if (instSent < NUM_INST + 1 && instFree && r[0]) begin
                sendFetch(WIN_BASE + ADDR_W'(nextRand() & 16'h00ff));
            end
            if (lsSent < NUM_LS + 1 && lsFree && r[1]) begin
                sendLs(memOpE'(r[2]), WIN_BASE + ADDR_W'(r[15:8]), lenT'(r[4:3]),
                       {nextRand(), nextRand()});
            end
        end

        drain = 0;
        while ((instQ.size() != 0 || lsQ.size() != 0) && drain < DRAIN_CYCLES) begin
            tick();
            drain++;
        end
        checkLen("outstanding fetches", 0, instQ.size());
        checkLen("outstanding loads/stores", 0, lsQ.size());
        // late extra pulses would show up here
        repeat (5) tick();
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, %0d fetches and %0d loads/stores outstanding",
                     cycleCount, instQ.size(), lsQ.size());
            $display("Test failed");
            $finish;
        end
    end

endmodule

// File: memSubsys.f
memPkg.sv
byteRam.sv
memReqSlots.sv
memSequencer.sv
memSubsys.sv
memSubsys_checker.sv
memSubsys_tb.sv

// File: runSim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module memSubsys_tb -f memSubsys.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
